/* aud_dsp_top.f */
verilog/aud_dsp_pkg.sv
verilog/playback_ctrl.sv
verilog/sample_addr_gen.sv
verilog/sample_interp.sv
verilog/aud_dsp_top.sv
verif/aud_dsp_assert.sv
verif/tb_aud_dsp.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator and run it
# the simulator exit status is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_aud_dsp \
    --Mdir obj_dir \
    -o sim_aud_dsp \
    -f aud_dsp_top.f

./obj_dir/sim_aud_dsp

/* verif/tb_aud_dsp.sv */
`timescale 1ns/1ps

module tb_aud_dsp;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 3;
    localparam int GAP            = 8;
    localparam int SEG_OVERHEAD   = 13;
    localparam int NORMAL_CYCLES  = 160;
    localparam int FAST_CYCLES    = 120;
    localparam int HOLD_CYCLES    = 320;
    localparam int LINEAR_CYCLES  = 400;
    localparam int PAUSE_CYCLES   = 60;
    localparam int FIN_TIMEOUT    = 600;
    localparam int SESSIONS       = 12;
    localparam int SESSION_CYCLES = 150;
    localparam int TEST_CYCLES    = RESET_CYCLES + NORMAL_CYCLES + 3 * FAST_CYCLES
                                    + HOLD_CYCLES + 2 * LINEAR_CYCLES + 5 * PAUSE_CYCLES
                                    + 2 * FIN_TIMEOUT + SESSIONS * SESSION_CYCLES
                                    + 30 * SEG_OVERHEAD;
    localparam int WATCHDOG_NS    = (TEST_CYCLES + 500) * CLK_PERIOD;

    logic                     i_clk = 1'b0;
    logic                     i_rst_n;
    logic                     i_start;
    logic                     i_pause;
    logic                     i_stop;
    logic                     i_fast;
    logic                     i_slow_0;
    logic                     i_slow_1;
    logic                     i_daclrck;
    aud_dsp_pkg::speed_t      i_speed;
    aud_dsp_pkg::sample_t     i_sram_data;
    aud_dsp_pkg::sram_addr_t  i_stop_addr;
    aud_dsp_pkg::sample_t     o_dac_data;
    aud_dsp_pkg::sram_addr_t  o_sram_addr;
    logic                     o_fin;
    aud_dsp_pkg::play_state_t o_state;

    int seed = 46;

    // reference model state
    aud_dsp_pkg::play_state_t m_state;
    aud_dsp_pkg::play_mode_t  m_mode;
    aud_dsp_pkg::sram_addr_t  m_addr;
    aud_dsp_pkg::phase_t      m_phase;
    aud_dsp_pkg::sample_t     m_prev;
    aud_dsp_pkg::sample_t     m_cur;
    aud_dsp_pkg::sample_t     m_dac;
    aud_dsp_pkg::sample_t     m_dac_nxt;
    logic                     m_fin;
    logic                     m_lr_q;
    logic                     m_rise;
    logic                     m_fall;
    logic                     m_due;
    logic                     m_at_end;

    aud_dsp_top dut0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_fast      (i_fast),
        .i_slow_0    (i_slow_0),
        .i_slow_1    (i_slow_1),
        .i_daclrck   (i_daclrck),
        .i_speed     (i_speed),
        .i_sram_data (i_sram_data),
        .i_stop_addr (i_stop_addr),
        .o_dac_data  (o_dac_data),
        .o_sram_addr (o_sram_addr),
        .o_fin       (o_fin),
        .o_state     (o_state)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // sram contents scrambled by a constant multiply of the address
    function automatic aud_dsp_pkg::sample_t sram_word(input aud_dsp_pkg::sram_addr_t a);
        logic [31:0] p;
        p = {12'h0, a} * 32'h9E37_79B1;
        return aud_dsp_pkg::sample_t'(p[31:16]);
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return r % n;
    endfunction

    assign i_sram_data = sram_word(o_sram_addr);

    task automatic stop_with_failure;
        $display("ERRORS FOUND");
        $fatal(1, "simulation aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        stop_with_failure();
    endtask

    // frame clock with half periods of 4 to 8 clocks
    initial begin
        i_daclrck = 1'b0;
        forever begin
            repeat (4 + rand_below(5)) @(posedge i_clk);
            i_daclrck <= ~i_daclrck;
        end
    end

    always_comb begin
        int divisor;
        int w_cur;
        int acc;
        if (i_fast) begin
            m_mode = aud_dsp_pkg::MODE_FAST;
        end else if (i_slow_0) begin
            m_mode = aud_dsp_pkg::MODE_HOLD;
        end else if (i_slow_1) begin
            m_mode = aud_dsp_pkg::MODE_LINEAR;
        end else begin
            m_mode = aud_dsp_pkg::MODE_NORMAL;
        end
        m_rise   = i_daclrck && !m_lr_q;
        m_fall   = !i_daclrck && m_lr_q;
        m_due    = int'(m_phase) > int'(i_speed);
        m_at_end = m_addr >= i_stop_addr;
        m_cur    = sram_word(m_addr);
        divisor  = int'(i_speed) + 1;
        w_cur    = int'(m_phase);
        acc      = int'(m_prev) * (divisor - w_cur) + int'(m_cur) * w_cur;
        if (m_state != aud_dsp_pkg::ST_PLAY) begin
            m_dac_nxt = '0;
        end else if (m_mode == aud_dsp_pkg::MODE_LINEAR) begin
            m_dac_nxt = aud_dsp_pkg::sample_t'(acc / divisor);
        end else begin
            m_dac_nxt = m_cur;
        end
    end

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_state <= aud_dsp_pkg::ST_IDLE;
            m_addr  <= '0;
            m_phase <= '0;
            m_prev  <= '0;
            m_dac   <= '0;
            m_fin   <= 1'b0;
            m_lr_q  <= 1'b0;
        end else begin
            m_lr_q <= i_daclrck;
            m_dac  <= m_dac_nxt;
            m_fin  <= 1'b0;
            case (m_state)
                aud_dsp_pkg::ST_IDLE: begin
                    m_addr  <= '0;
                    m_phase <= '0;
                    m_prev  <= '0;
                    if (i_start) begin
                        m_state <= aud_dsp_pkg::ST_PLAY;
                    end
                end
                aud_dsp_pkg::ST_PLAY: begin
                    if (i_stop || m_at_end) begin
                        m_state <= aud_dsp_pkg::ST_IDLE;
                        m_fin   <= 1'b1;
                    end else if (i_pause) begin
                        m_state <= aud_dsp_pkg::ST_PAUSE;
                    end
                    if (m_rise && m_due) begin
                        m_prev <= m_cur;
                    end
                    if (m_fall) begin
                        if (m_mode == aud_dsp_pkg::MODE_FAST) begin
                            m_addr  <= m_addr + aud_dsp_pkg::sram_addr_t'(i_speed) + 20'd1;
                            m_phase <= '0;
                        end else if (m_mode == aud_dsp_pkg::MODE_NORMAL) begin
                            m_addr  <= m_addr + 20'd1;
                            m_phase <= '0;
                        end else if (m_due) begin
                            m_addr  <= m_addr + 20'd1;
                            m_phase <= 4'd1;
                        end else begin
                            m_phase <= m_phase + 4'd1;
                        end
                    end
                end
                default: begin
                    if (i_start) begin
                        m_state <= aud_dsp_pkg::ST_PLAY;
                    end else if (i_stop) begin
                        m_state <= aud_dsp_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // compare away from the active edge
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            assert (o_sram_addr == m_addr)
                else report_mismatch("o_sram_addr", {12'h0, m_addr}, {12'h0, o_sram_addr});
            assert (o_dac_data == m_dac)
                else report_mismatch("o_dac_data", {16'h0, m_dac}, {16'h0, o_dac_data});
            assert (o_fin == m_fin)
                else report_mismatch("o_fin", {31'h0, m_fin}, {31'h0, o_fin});
            assert (o_state == m_state)
                else report_mismatch("o_state", {30'h0, m_state}, {30'h0, o_state});
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    task automatic pulse_start;
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    task automatic pulse_pause;
        @(posedge i_clk);
        i_pause <= 1'b1;
        @(posedge i_clk);
        i_pause <= 1'b0;
    endtask

    task automatic pulse_stop;
        @(posedge i_clk);
        i_stop <= 1'b1;
        @(posedge i_clk);
        i_stop <= 1'b0;
    endtask

    // mode levels and speed only change while idle
    task automatic set_mode(input logic fast, input logic slow_0, input logic slow_1);
        @(posedge i_clk);
        i_fast   <= fast;
        i_slow_0 <= slow_0;
        i_slow_1 <= slow_1;
        i_speed  <= aud_dsp_pkg::speed_t'(rand_below(8));
    endtask

    task automatic run_segment(input logic fast, input logic slow_0, input logic slow_1,
                               input int cycles);
        set_mode(fast, slow_0, slow_1);
        pulse_start();
        wait_cycles(cycles);
        pulse_stop();
        wait_cycles(GAP);
    endtask

    task automatic wait_for_fin(input int limit);
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (!o_fin && waited < limit) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_fin) begin
            $display("o_fin did not pulse within %0d cycles of the start", limit);
            stop_with_failure();
        end
    endtask

    task automatic run_to_stop_addr(input logic fast, input int stop_at);
        set_mode(fast, 1'b0, 1'b0);
        i_stop_addr <= aud_dsp_pkg::sram_addr_t'(stop_at);
        pulse_start();
        wait_for_fin(FIN_TIMEOUT);
        @(posedge i_clk);
        i_stop_addr <= '1;
        wait_cycles(GAP);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, run did not finish within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    initial begin
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_pause     = 1'b0;
        i_stop      = 1'b0;
        i_fast      = 1'b0;
        i_slow_0    = 1'b0;
        i_slow_1    = 1'b0;
        i_speed     = '0;
        i_stop_addr = '1;
        wait_cycles(RESET_CYCLES);
        i_rst_n <= 1'b1;
        wait_cycles(2);

        run_segment(1'b0, 1'b0, 1'b0, NORMAL_CYCLES);
        repeat (3) run_segment(1'b1, 1'b0, 1'b0, FAST_CYCLES);
        run_segment(1'b0, 1'b1, 1'b0, HOLD_CYCLES);
        repeat (2) run_segment(1'b0, 1'b0, 1'b1, LINEAR_CYCLES);

        // pause and resume then stop out of pause
        set_mode(1'b0, 1'b0, 1'b0);
        pulse_start();
        wait_cycles(PAUSE_CYCLES);
        pulse_pause();
        wait_cycles(PAUSE_CYCLES);
        pulse_start();
        wait_cycles(PAUSE_CYCLES);
        pulse_pause();
        wait_cycles(PAUSE_CYCLES / 2);
        pulse_stop();
        wait_cycles(GAP);

        run_to_stop_addr(1'b0, 12);
        run_to_stop_addr(1'b1, 24);

        // random sessions draw all mode levels at once to hit the priority
        repeat (SESSIONS) begin
            set_mode(rand_below(4) == 0, rand_below(3) == 0, rand_below(2) == 0);
            i_stop_addr <= aud_dsp_pkg::sram_addr_t'(8 + rand_below(64));
            pulse_start();
            repeat (SESSION_CYCLES) begin
                @(posedge i_clk);
                i_start <= (rand_below(20) == 0);
                i_pause <= (rand_below(30) == 0);
                i_stop  <= (rand_below(90) == 0);
            end
            @(posedge i_clk);
            i_start <= 1'b0;
            i_pause <= 1'b0;
            i_stop  <= 1'b1;
            @(posedge i_clk);
            i_stop <= 1'b0;
            wait_cycles(GAP);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* verif/aud_dsp_assert.sv */
`timescale 1ns/1ps

module aud_dsp_assert (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_fin,
    input aud_dsp_pkg::play_state_t i_state,
    input aud_dsp_pkg::sample_t     i_dac_data,
    input aud_dsp_pkg::sram_addr_t  i_sram_addr
);

    // finish is a single cycle pulse
    fin_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fin |=> !i_fin)
        else $error("o_fin was high for two cycles in a row");

    fin_in_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fin |-> (i_state == aud_dsp_pkg::ST_IDLE))
        else $error("o_fin high while the state is not idle");

    // output register lags the state by one cycle
    dac_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state != aud_dsp_pkg::ST_PLAY && $past(i_state) != aud_dsp_pkg::ST_PLAY)
        |-> (i_dac_data == '0))
        else $error("o_dac_data not zero outside play");

    addr_frozen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_state == aud_dsp_pkg::ST_PAUSE) |=> $stable(i_sram_addr))
        else $error("o_sram_addr moved during pause");

endmodule

bind aud_dsp_top aud_dsp_assert u_assert (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_fin       (o_fin),
    .i_state     (o_state),
    .i_dac_data  (o_dac_data),
    .i_sram_addr (o_sram_addr)
);

/* verilog/aud_dsp_top.sv */
`timescale 1ns/1ps

module aud_dsp_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_pause,
    input  logic                     i_stop,
    input  logic                     i_fast,
    input  logic                     i_slow_0,
    input  logic                     i_slow_1,
    input  logic                     i_daclrck,
    input  aud_dsp_pkg::speed_t      i_speed,
    input  aud_dsp_pkg::sample_t     i_sram_data,
    input  aud_dsp_pkg::sram_addr_t  i_stop_addr,
    output aud_dsp_pkg::sample_t     o_dac_data,
    output aud_dsp_pkg::sram_addr_t  o_sram_addr,
    output logic                     o_fin,
    output aud_dsp_pkg::play_state_t o_state
);

    aud_dsp_pkg::play_state_t state;
    aud_dsp_pkg::play_mode_t  mode;
    aud_dsp_pkg::phase_t      phase;
    logic                     step_due;
    logic                     lrclk_rise;
    logic                     at_end;

    playback_ctrl u_ctrl (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_pause  (i_pause),
        .i_stop   (i_stop),
        .i_fast   (i_fast),
        .i_slow_0 (i_slow_0),
        .i_slow_1 (i_slow_1),
        .i_at_end (at_end),
        .o_state  (state),
        .o_mode   (mode),
        .o_fin    (o_fin)
    );

    sample_addr_gen u_addr (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_daclrck    (i_daclrck),
        .i_state      (state),
        .i_mode       (mode),
        .i_speed      (i_speed),
        .i_stop_addr  (i_stop_addr),
        .o_sram_addr  (o_sram_addr),
        .o_phase      (phase),
        .o_step_due   (step_due),
        .o_lrclk_rise (lrclk_rise),
        .o_lrclk_fall (),
        .o_at_end     (at_end)
    );

    // fall edge is consumed by the address stepping only
    sample_interp u_interp (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_state      (state),
        .i_mode       (mode),
        .i_speed      (i_speed),
        .i_phase      (phase),
        .i_step_due   (step_due),
        .i_lrclk_rise (lrclk_rise),
        .i_sram_data  (i_sram_data),
        .o_dac_data   (o_dac_data)
    );

    assign o_state = state;

endmodule

/* verilog/sample_interp.sv */
`timescale 1ns/1ps

module sample_interp (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  aud_dsp_pkg::play_state_t i_state,
    input  aud_dsp_pkg::play_mode_t  i_mode,
    input  aud_dsp_pkg::speed_t      i_speed,
    input  aud_dsp_pkg::phase_t      i_phase,
    input  logic                     i_step_due,
    input  logic                     i_lrclk_rise,
    input  aud_dsp_pkg::sample_t     i_sram_data,
    output aud_dsp_pkg::sample_t     o_dac_data
);

    aud_dsp_pkg::sample_t prev_r;
    logic signed [5:0]    w_prev;
    logic signed [5:0]    w_cur;
    logic signed [5:0]    divisor;
    logic signed [23:0]   acc;
    logic signed [23:0]   quot;
    aud_dsp_pkg::sample_t dac_nxt;

    // weights of the two neighbouring samples
    assign divisor = $signed({3'b000, i_speed}) + 6'sd1;
    assign w_cur   = $signed({2'b00, i_phase});
    assign w_prev  = divisor - w_cur;

    assign acc  = prev_r * w_prev + i_sram_data * w_cur;
    // signed division rounds toward zero
    assign quot = acc / divisor;

    // previous sample captured once the current one has been fully used
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prev_r <= '0;
        end else begin
            case (i_state)
                aud_dsp_pkg::ST_IDLE: begin
                    prev_r <= '0;
                end
                aud_dsp_pkg::ST_PLAY: begin
                    if (i_lrclk_rise && i_step_due) begin
                        prev_r <= i_sram_data;
                    end
                end
                default: begin
                    prev_r <= prev_r;
                end
            endcase
        end
    end

    always_comb begin
        if (i_state != aud_dsp_pkg::ST_PLAY) begin
            dac_nxt = '0;
        end else if (i_mode == aud_dsp_pkg::MODE_LINEAR) begin
            dac_nxt = quot[15:0];
        end else begin
            // normal, fast and hold pass the SRAM word straight on
            dac_nxt = i_sram_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dac_data <= '0;
        end else begin
            o_dac_data <= dac_nxt;
        end
    end

endmodule

/* verilog/sample_addr_gen.sv */
`timescale 1ns/1ps

module sample_addr_gen (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_daclrck,
    input  aud_dsp_pkg::play_state_t i_state,
    input  aud_dsp_pkg::play_mode_t  i_mode,
    input  aud_dsp_pkg::speed_t      i_speed,
    input  aud_dsp_pkg::sram_addr_t  i_stop_addr,
    output aud_dsp_pkg::sram_addr_t  o_sram_addr,
    output aud_dsp_pkg::phase_t      o_phase,
    output logic                     o_step_due,
    output logic                     o_lrclk_rise,
    output logic                     o_lrclk_fall,
    output logic                     o_at_end
);

    logic                    daclrck_q;
    aud_dsp_pkg::sram_addr_t addr_r;
    aud_dsp_pkg::phase_t     phase_r;
    logic                    step_due;

    // edges against the last sampled level
    assign o_lrclk_rise = i_daclrck & ~daclrck_q;
    assign o_lrclk_fall = ~i_daclrck & daclrck_q;

    // current sample has been used for speed+1 frames
    assign step_due = phase_r > {1'b0, i_speed};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            daclrck_q <= 1'b0;
        end else begin
            daclrck_q <= i_daclrck;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_r  <= '0;
            phase_r <= '0;
        end else begin
            case (i_state)
                aud_dsp_pkg::ST_IDLE: begin
                    addr_r  <= '0;
                    phase_r <= '0;
                end
                aud_dsp_pkg::ST_PLAY: begin
                    // one step per frame, taken on the falling edge
                    if (o_lrclk_fall) begin
                        case (i_mode)
                            aud_dsp_pkg::MODE_FAST: begin
                                addr_r  <= addr_r + aud_dsp_pkg::sram_addr_t'(i_speed)
                                           + aud_dsp_pkg::sram_addr_t'(1);
                                phase_r <= '0;
                            end
                            aud_dsp_pkg::MODE_HOLD,
                            aud_dsp_pkg::MODE_LINEAR: begin
                                if (step_due) begin
                                    addr_r  <= addr_r + aud_dsp_pkg::sram_addr_t'(1);
                                    phase_r <= aud_dsp_pkg::phase_t'(1);
                                end else begin
                                    phase_r <= phase_r + aud_dsp_pkg::phase_t'(1);
                                end
                            end
                            default: begin
                                addr_r  <= addr_r + aud_dsp_pkg::sram_addr_t'(1);
                                phase_r <= '0;
                            end
                        endcase
                    end
                end
                aud_dsp_pkg::ST_PAUSE: begin
                    // hold position until resumed
                    addr_r  <= addr_r;
                    phase_r <= phase_r;
                end
                default: begin
                    addr_r  <= '0;
                    phase_r <= '0;
                end
            endcase
        end
    end

    assign o_at_end    = addr_r >= i_stop_addr;
    assign o_sram_addr = addr_r;
    assign o_phase     = phase_r;
    assign o_step_due  = step_due;

endmodule

/* verilog/playback_ctrl.sv */
`timescale 1ns/1ps

module playback_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_pause,
    input  logic                     i_stop,
    input  logic                     i_fast,
    input  logic                     i_slow_0,
    input  logic                     i_slow_1,
    input  logic                     i_at_end,
    output aud_dsp_pkg::play_state_t o_state,
    output aud_dsp_pkg::play_mode_t  o_mode,
    output logic                     o_fin
);

    aud_dsp_pkg::play_state_t state_r;
    aud_dsp_pkg::play_state_t state_nxt;
    logic                     fin_nxt;

    // fast first, then constant hold, then linear
    always_comb begin
        if (i_fast) begin
            o_mode = aud_dsp_pkg::MODE_FAST;
        end else if (i_slow_0) begin
            o_mode = aud_dsp_pkg::MODE_HOLD;
        end else if (i_slow_1) begin
            o_mode = aud_dsp_pkg::MODE_LINEAR;
        end else begin
            o_mode = aud_dsp_pkg::MODE_NORMAL;
        end
    end

    always_comb begin
        state_nxt = state_r;
        fin_nxt   = 1'b0;
        case (state_r)
            aud_dsp_pkg::ST_IDLE: begin
                if (i_start) begin
                    state_nxt = aud_dsp_pkg::ST_PLAY;
                end
            end
            aud_dsp_pkg::ST_PLAY: begin
                // stop and end of data beat pause
                if (i_stop || i_at_end) begin
                    state_nxt = aud_dsp_pkg::ST_IDLE;
                    fin_nxt   = 1'b1;
                end else if (i_pause) begin
                    state_nxt = aud_dsp_pkg::ST_PAUSE;
                end
            end
            aud_dsp_pkg::ST_PAUSE: begin
                if (i_start) begin
                    state_nxt = aud_dsp_pkg::ST_PLAY;
                end else if (i_stop) begin
                    // leaving pause by stop gives no finish pulse
                    state_nxt = aud_dsp_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = aud_dsp_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= aud_dsp_pkg::ST_IDLE;
            o_fin   <= 1'b0;
        end else begin
            state_r <= state_nxt;
            o_fin   <= fin_nxt;
        end
    end

    assign o_state = state_r;

endmodule

/* verilog/aud_dsp_pkg.sv */
package aud_dsp_pkg;

    // one signed sample as stored in the SRAM and sent to the codec
    typedef logic signed [15:0] sample_t;

    // word address into the sample SRAM
    typedef logic [19:0] sram_addr_t;

    // speed setting, real factor is speed+1
    typedef logic [2:0] speed_t;

    // frames spent so far on the current sample in the slow modes
    typedef logic [3:0] phase_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2
    } play_state_t;

    // decoded playback mode
    // MODE_HOLD repeats a sample, MODE_LINEAR interpolates
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_FAST   = 2'd1,
        MODE_HOLD   = 2'd2,
        MODE_LINEAR = 2'd3
    } play_mode_t;

endpackage
